//--- bench/soc_ctrl_props.sv
// apb response properties, bound into soc_ctrl_top
// assumes the master raises penable only towards an idle slave
`default_nettype none

module soc_ctrl_props (
  input logic HCLK,
  input logic HRESETn,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i
);

  timeunit 1ns;
  timeprecision 100ps;

  ready_single_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pready_i |=> !pready_i)
    else $error("pready_o stayed high for two cycles");

  slverr_with_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pslverr_i |-> pready_i)
    else $error("pslverr_o high without pready_o");

  // pready is set on the second edge, so it samples high one edge later
  fixed_latency: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(psel_i && penable_i) |-> ##3 $rose(pready_i))
    else $error("pready_o did not rise two cycles after the access phase");

endmodule

`default_nettype wire

//--- bench/soc_ctrl_tb.sv
// random apb testbench for soc_ctrl_top checked against a register map model
// assumes default parameters and a bootsel strap held high through reset
// stops at the first mismatch
`default_nettype none

module soc_ctrl_tb
  import soc_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned N_IO          = 32;
  localparam int unsigned JTAG_REG_SIZE = 8;
  localparam int unsigned CLK_PERIOD    = 4;
  localparam int unsigned N_TRANS       = 500;  // planned apb transfers
  localparam int unsigned WATCHDOG_NS   = N_TRANS * 200 * CLK_PERIOD;
  localparam logic [31:0] SEED          = 32'h14bd78f1;

  logic                             HCLK = 1'b0;
  logic                             HRESETn;
  logic [APB_ADDR_WIDTH-1:0]        paddr_i;
  logic [31:0]                      pwdata_i;
  logic                             pwrite_i;
  logic                             psel_i;
  logic                             penable_i;
  logic [31:0]                      prdata_o;
  logic                             pready_o;
  logic                             pslverr_o;
  logic                             bootsel_i;
  logic                             fc_fetch_en_valid_i;
  logic                             fc_fetch_en_i;
  logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_i;
  logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_o;
  logic [N_IO-1:0][NBIT_PADCFG-1:0] pad_cfg_o;
  logic [N_IO-1:0][NBIT_PADMUX-1:0] pad_mux_o;
  logic [31:0]                      fc_bootaddr_o;
  logic                             fc_fetchen_o;
  logic                             cluster_byp_o;
  logic                             cluster_pow_o;
  logic                             cluster_fetch_enable_o;
  logic                             cluster_rstn_o;
  logic                             cluster_irq_o;
  logic [63:0]                      cluster_boot_addr_o;

  // register map model
  logic [31:0]              m_fcboot;
  logic                     m_fetch;
  logic [3:0]               m_ctrl;  // rstn, fetch enable, pow, byp
  logic                     m_irq;
  logic [63:0]              m_boot;
  logic [31:0]              m_status;
  logic [JTAG_REG_SIZE-1:0] m_jtag_out;
  logic [JTAG_REG_SIZE-1:0] m_jtag_in;
  logic [7:0]               m_ptr;
  logic [NBIT_PADCFG-1:0]   m_cfg [N_IO];
  logic [NBIT_PADMUX-1:0]   m_mux [N_IO];

  soc_ctrl_top #(.N_IO(N_IO), .JTAG_REG_SIZE(JTAG_REG_SIZE)) soc_ctrl_top_inst (.*);

  bind soc_ctrl_top soc_ctrl_props props_inst (
    .HCLK(HCLK), .HRESETn(HRESETn), .psel_i(psel_i), .penable_i(penable_i),
    .pready_i(pready_o), .pslverr_i(pslverr_o)
  );

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", what, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  function automatic void model_reset();
    m_fcboot   = FCBOOT_RST;
    m_fetch    = 1'b0;
    m_ctrl     = 4'b1001;  // bypass on and cluster out of reset
    m_irq      = 1'b0;
    m_boot     = '0;
    m_status   = '0;
    m_jtag_out = '0;
    m_jtag_in  = '0;
    m_ptr      = '0;
    for (int p = 0; p < N_IO; p++) begin
      m_cfg[p] = '1;
      m_mux[p] = '0;
    end
  endfunction

  function automatic bit model_err(input logic wr, input logic [11:0] a);
    if (a[11:10] == PAD_WIN_TAG) return 32'(a[9:2]) >= N_IO;
    case (a)
      OFS_INFO, OFS_CS_RO, OFS_BOOTSEL: return wr;  // read only
      OFS_FCBOOT, OFS_FCFETCH, OFS_WCFGFUN, OFS_RCFGFUN, OFS_CLUSTER_CTRL, OFS_JTAGREG,
      OFS_CLUSTER_IRQ, OFS_CLUSTER_BOOT0, OFS_CLUSTER_BOOT1, OFS_CORESTATUS: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic [31:0] model_rdata(input logic [11:0] a);
    logic [31:0] w;
    logic [7:0]  i;
    w = '0;
    i = a[9:2];
    if (a[11:10] == PAD_WIN_TAG) begin
      if (32'(i) >= N_IO) return RDATA_NOPAD;
      w[13:8] = m_cfg[i];
      w[1:0]  = m_mux[i];
      return w;
    end
    case (a)
      OFS_INFO:    w = 32'h0004_0001;  // 4 cores and 1 cluster
      OFS_FCBOOT:  w = m_fcboot;
      OFS_FCFETCH: w[0] = m_fetch;
      OFS_WCFGFUN, OFS_RCFGFUN: begin
        w[7:0] = m_ptr;
        if (32'(m_ptr) < N_IO) begin
          w[17:16] = m_mux[m_ptr];
          w[29:24] = m_cfg[m_ptr];
        end
      end
      OFS_CLUSTER_CTRL:          w[3:0] = m_ctrl;
      OFS_JTAGREG:               w[15:0] = {m_jtag_in, m_jtag_out};
      OFS_CLUSTER_IRQ:           w[0] = m_irq;
      OFS_CLUSTER_BOOT0:         w = m_boot[31:0];
      OFS_CLUSTER_BOOT1:         w = m_boot[63:32];
      OFS_CORESTATUS, OFS_CS_RO: w = m_status;
      OFS_BOOTSEL:               w = {bootsel_i, 30'h0, 1'b1};  // live strap over the reset one
      default:                   w = RDATA_ERR;
    endcase
    return w;
  endfunction

  function automatic void model_write(input logic [11:0] a, input logic [31:0] d);
    if (a[11:10] == PAD_WIN_TAG) begin
      m_ptr          = a[9:2];
      m_cfg[a[9:2]]  = d[13:8];
      m_mux[a[9:2]]  = d[1:0];
    end else begin
      case (a)
        OFS_FCBOOT:  m_fcboot = d;
        OFS_FCFETCH: m_fetch = d[0];
        OFS_WCFGFUN: begin
          m_ptr = d[7:0];
          if (32'(d[7:0]) < N_IO) begin  // out of range only moves the pointer
            m_cfg[d[7:0]] = d[29:24];
            m_mux[d[7:0]] = d[17:16];
          end
        end
        OFS_RCFGFUN:       m_ptr = d[7:0];
        OFS_CLUSTER_CTRL:  m_ctrl = d[3:0];
        OFS_JTAGREG:       m_jtag_out = d[JTAG_REG_SIZE-1:0];
        OFS_CLUSTER_IRQ:   m_irq = d[0];
        OFS_CLUSTER_BOOT0: m_boot[31:0] = d;
        OFS_CLUSTER_BOOT1: m_boot[63:32] = d;
        OFS_CORESTATUS:    m_status = d;
        default: ;
      endcase
    end
  endfunction

  task automatic check_outputs();
    check("fc_bootaddr_o", 64'(fc_bootaddr_o), 64'(m_fcboot));
    check("fc_fetchen_o", 64'(fc_fetchen_o), 64'(m_fetch));
    check("cluster_{rstn,fetch_enable,pow,byp}_o",
          64'({cluster_rstn_o, cluster_fetch_enable_o, cluster_pow_o, cluster_byp_o}),
          64'(m_ctrl));
    check("cluster_irq_o", 64'(cluster_irq_o), 64'(m_irq));
    check("cluster_boot_addr_o", cluster_boot_addr_o, m_boot);
    check("soc_jtag_reg_o", 64'(soc_jtag_reg_o), 64'(m_jtag_out));
    for (int p = 0; p < N_IO; p++) begin
      check($sformatf("pad_cfg_o[%0d]", p), 64'(pad_cfg_o[p]), 64'(m_cfg[p]));
      check($sformatf("pad_mux_o[%0d]", p), 64'(pad_mux_o[p]), 64'(m_mux[p]));
    end
  endtask

  // setup phase, access phase, then wait for pready
  task automatic apb_xfer(input logic wr, input logic [11:0] a, input logic [31:0] d,
                          output logic [31:0] rd, output logic err);
    int edges;
    @(posedge HCLK);
    #1;
    psel_i   = 1'b1;
    pwrite_i = wr;
    paddr_i  = a;
    pwdata_i = d;
    @(posedge HCLK);
    #1;
    penable_i = 1'b1;
    edges     = 0;
    do begin
      @(posedge HCLK);
      #1;
      edges++;
    end while (!pready_o);
    check("pready_o latency in edges", 64'(edges), 64'd3);  // E0, E1, then E2
    rd        = prdata_o;
    err       = pslverr_o;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] a, input logic [31:0] d);
    logic [31:0] rd;
    logic        err;
    logic        exp_err;
    exp_err = model_err(1'b1, a);
    apb_xfer(1'b1, a, d, rd, err);
    check($sformatf("pslverr_o on write 0x%03h", a), 64'(err), 64'(exp_err));
    if (!exp_err) model_write(a, d);
    check_outputs();
  endtask

  task automatic apb_read(input logic [11:0] a);
    logic [31:0] rd;
    logic        err;
    logic [31:0] exp_rd;
    logic        exp_err;
    exp_rd  = model_rdata(a);
    exp_err = model_err(1'b0, a);
    apb_xfer(1'b0, a, 32'h0, rd, err);
    check($sformatf("prdata_o on read 0x%03h", a), 64'(rd), 64'(exp_rd));
    check($sformatf("pslverr_o on read 0x%03h", a), 64'(err), 64'(exp_err));
    if (a[11:10] == PAD_WIN_TAG && !exp_err) m_ptr = a[9:2];  // window read moves it
  endtask

  function automatic logic [11:0] rw_addr(input int unsigned k);
    case (k)
      0:       return OFS_FCBOOT;
      1:       return OFS_FCFETCH;
      2:       return OFS_CLUSTER_CTRL;
      3:       return OFS_JTAGREG;
      4:       return OFS_CLUSTER_IRQ;
      5:       return OFS_CLUSTER_BOOT0;
      6:       return OFS_CLUSTER_BOOT1;
      7:       return OFS_CORESTATUS;
      default: return OFS_CS_RO;
    endcase
  endfunction

  function automatic logic [11:0] unmapped_addr();
    logic [11:0] a;
    do begin
      a = 12'($urandom());
    end while (a[11:10] == PAD_WIN_TAG || !model_err(1'b0, a));
    return a;
  endfunction

  initial begin
    #WATCHDOG_NS;
    $display("watchdog expired, the run did not finish in time");
    $display("Test failures found");
    $fatal(1);
  end

  initial begin
    logic [11:0] a;
    logic [31:0] d;
    logic [7:0]  idx;
    int unsigned k;
    void'($urandom(SEED));
    HRESETn             = 1'b0;
    paddr_i             = '0;
    pwdata_i            = '0;
    pwrite_i            = 1'b0;
    psel_i              = 1'b0;
    penable_i           = 1'b0;
    bootsel_i           = 1'b1;
    fc_fetch_en_valid_i = 1'b0;
    fc_fetch_en_i       = 1'b0;
    soc_jtag_reg_i      = '0;
    model_reset();
    repeat (16) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;

    // reset values
    check_outputs();
    apb_read(OFS_INFO);
    apb_read(OFS_FCBOOT);
    apb_read(OFS_CLUSTER_CTRL);
    apb_read(OFS_BOOTSEL);

    // strap drops after capture and only the live bit follows
    @(posedge HCLK);
    #1;
    bootsel_i = 1'b0;
    apb_read(OFS_BOOTSEL);

    // random traffic on the read/write registers and the cs_ro mirror
    repeat (300) begin
      k = $urandom_range(0, 8);
      a = rw_addr(k);
      if (k != 8 && $urandom_range(0, 1) != 0) apb_write(a, $urandom());
      else apb_read(a);
    end

    // unmapped targets and writes to read-only ones
    repeat (40) begin
      a = unmapped_addr();
      if ($urandom_range(0, 1) != 0) apb_write(a, $urandom());
      else apb_read(a);
      k = $urandom_range(0, 2);
      apb_write((k == 0) ? OFS_INFO : (k == 1) ? OFS_CS_RO : OFS_BOOTSEL, $urandom());
    end
    for (int r = 0; r <= 8; r++) apb_read(rw_addr(r));  // state must be untouched

    // pad writes and reads through both paths with some indices out of range
    repeat (100) begin
      k   = $urandom_range(0, 4);
      idx = 8'($urandom_range(0, N_IO + 15));
      d   = $urandom();
      case (k)
        0:       apb_write({PAD_WIN_TAG, idx, 2'b00}, d);
        1:       apb_read({PAD_WIN_TAG, idx, 2'b00});
        2:       apb_write(OFS_WCFGFUN, {d[31:8], idx});
        3:       apb_write(OFS_RCFGFUN, {d[31:8], idx});
        default: apb_read(($urandom_range(0, 1) != 0) ? OFS_WCFGFUN : OFS_RCFGFUN);
      endcase
    end
    apb_read(12'h7FC);  // last window slot is pad 255

    // jtag input through the synchronizer
    @(posedge HCLK);
    #1;
    m_jtag_in      = JTAG_REG_SIZE'($urandom());
    soc_jtag_reg_i = m_jtag_in;
    repeat (3) @(posedge HCLK);
    apb_read(OFS_JTAGREG);

    // fetch override flipped each round so a change is visible
    for (int r = 0; r < 2; r++) begin
      @(posedge HCLK);
      #1;
      fc_fetch_en_valid_i = 1'b1;
      fc_fetch_en_i       = ~m_fetch;
      repeat (4) @(posedge HCLK);
      #1;
      fc_fetch_en_valid_i = 1'b0;
      m_fetch             = fc_fetch_en_i;
      repeat (4) @(posedge HCLK);  // sync stages drain
      #1;
      check_outputs();
      apb_read(OFS_FCFETCH);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/soc_ctrl_apb_seq.sv
// apb access sequencer with a fixed latency, pready rises two edges after
// the access phase is seen, no wait states from the slave side
// out of range pad indices decode to REG_NONE and keep a nonzero pad_idx_o
`default_nettype none

module soc_ctrl_apb_seq
  import soc_ctrl_pkg::*;
#(
  parameter int unsigned N_IO = 32
) (
  input  logic                      HCLK,
  input  logic                      HRESETn,
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic                      pwrite_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  output logic                      pready_o,
  output logic                      pslverr_o,
  output logic                      wr_stb_o,
  output logic                      rd_stb_o,
  output soc_reg_e                  reg_sel_o,
  output logic [7:0]                pad_idx_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_OPERATE, ST_RESPOND, ST_WAIT} seq_state_e;

  seq_state_e state_q;
  soc_reg_e   dec_sel;
  logic [7:0] dec_idx;
  logic       write_q;
  logic       access_err;

  always_comb begin
    dec_sel = REG_NONE;
    dec_idx = '0;  // stays zero for every non-pad address
    if (paddr_i[11:10] == PAD_WIN_TAG) begin
      dec_idx = paddr_i[9:2];
      if (32'(dec_idx) < N_IO) begin
        dec_sel = REG_PAD;
      end
    end else begin
      case (paddr_i)
        OFS_INFO:          dec_sel = REG_INFO;
        OFS_FCBOOT:        dec_sel = REG_FCBOOT;
        OFS_FCFETCH:       dec_sel = REG_FCFETCH;
        OFS_WCFGFUN:       dec_sel = REG_WCFG;
        OFS_RCFGFUN:       dec_sel = REG_RCFG;
        OFS_CLUSTER_CTRL:  dec_sel = REG_CLU_CTRL;
        OFS_JTAGREG:       dec_sel = REG_JTAG;
        OFS_CLUSTER_IRQ:   dec_sel = REG_CLU_IRQ;
        OFS_CLUSTER_BOOT0: dec_sel = REG_CLU_BOOT0;
        OFS_CLUSTER_BOOT1: dec_sel = REG_CLU_BOOT1;
        OFS_CORESTATUS:    dec_sel = REG_CORESTATUS;
        OFS_CS_RO:         dec_sel = REG_CS_RO;
        OFS_BOOTSEL:       dec_sel = REG_BOOTSEL;
        default:           dec_sel = REG_NONE;
      endcase
    end
  end

  // unmapped target, or a write into a read-only one
  assign access_err = (reg_sel_o == REG_NONE) ||
                      (write_q && (reg_sel_o inside {REG_INFO, REG_CS_RO, REG_BOOTSEL}));

  assign wr_stb_o = (state_q == ST_RESPOND) && write_q && !access_err;
  assign rd_stb_o = (state_q == ST_RESPOND) && !write_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q   <= ST_IDLE;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
      reg_sel_o <= REG_NONE;
      pad_idx_o <= '0;
      write_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: if (psel_i && penable_i) state_q <= ST_OPERATE;
        ST_OPERATE: begin  // latch the decode, strobes follow
          reg_sel_o <= dec_sel;
          pad_idx_o <= dec_idx;
          write_q   <= pwrite_i;
          state_q   <= ST_RESPOND;
        end
        ST_RESPOND: begin
          pready_o  <= 1'b1;
          pslverr_o <= access_err;
          state_q   <= ST_WAIT;
        end
        default: begin  // master drops penable here
          pready_o  <= 1'b0;
          pslverr_o <= 1'b0;
          state_q   <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/soc_ctrl_padcfg.sv
// per pad configuration and mux table plus the indirect pad pointer
// pad_idx_i is trusted, the sequencer only sends REG_PAD for indices below N_IO
// the pointer may hold an out of range index after a wcfg or rcfg write
`default_nettype none

module soc_ctrl_padcfg
  import soc_ctrl_pkg::*;
#(
  parameter int unsigned N_IO = 32
) (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  logic                                wr_stb_i,
  input  logic                                rd_stb_i,
  input  soc_reg_e                            reg_sel_i,
  input  logic [7:0]                          pad_idx_i,
  input  logic [31:0]                         pwdata_i,
  output logic [N_IO-1:0][NBIT_PADCFG-1:0]    pad_cfg_o,
  output logic [N_IO-1:0][NBIT_PADMUX-1:0]    pad_mux_o,
  output logic [7:0]                          pad_ptr_o
);

  logic [7:0] wr_ptr;    // pad index carried in the write data
  logic       wr_ptr_ok;

  assign wr_ptr    = pwdata_i[7:0];
  assign wr_ptr_ok = 32'(wr_ptr) < N_IO;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      pad_cfg_o <= '1;
      pad_mux_o <= '0;
      pad_ptr_o <= '0;
    end else if (wr_stb_i) begin
      case (reg_sel_i)
        REG_PAD: begin  // direct window
          pad_ptr_o            <= pad_idx_i;
          pad_cfg_o[pad_idx_i] <= pwdata_i[8+:NBIT_PADCFG];
          pad_mux_o[pad_idx_i] <= pwdata_i[0+:NBIT_PADMUX];
        end
        REG_WCFG: begin
          pad_ptr_o <= wr_ptr;
          if (wr_ptr_ok) begin
            pad_cfg_o[wr_ptr] <= pwdata_i[24+:NBIT_PADCFG];
            pad_mux_o[wr_ptr] <= pwdata_i[16+:NBIT_PADMUX];
          end
        end
        REG_RCFG: pad_ptr_o <= wr_ptr;  // select only
        default: ;
      endcase
    end else if (rd_stb_i && (reg_sel_i == REG_PAD)) begin
      pad_ptr_o <= pad_idx_i;  // a window read also moves the pointer
    end
  end

endmodule

`default_nettype wire

//--- hdl/soc_ctrl_pkg.sv
// shared constants and types of the soc control block
// offsets are byte addresses inside a 4 KB apb window, word aligned
`default_nettype none

package soc_ctrl_pkg;

  localparam int unsigned NBIT_PADCFG    = 6;
  localparam int unsigned NBIT_PADMUX    = 2;
  localparam int unsigned APB_ADDR_WIDTH = 12;

  localparam logic [11:0] OFS_INFO          = 12'h000;  // cores and clusters
  localparam logic [11:0] OFS_FCBOOT        = 12'h004;
  localparam logic [11:0] OFS_FCFETCH       = 12'h008;
  localparam logic [11:0] OFS_WCFGFUN       = 12'h060;  // indirect pad write
  localparam logic [11:0] OFS_RCFGFUN       = 12'h064;  // indirect pad select
  localparam logic [11:0] OFS_CLUSTER_CTRL  = 12'h070;
  localparam logic [11:0] OFS_JTAGREG       = 12'h074;
  localparam logic [11:0] OFS_CLUSTER_IRQ   = 12'h07C;
  localparam logic [11:0] OFS_CLUSTER_BOOT0 = 12'h080;
  localparam logic [11:0] OFS_CLUSTER_BOOT1 = 12'h084;
  localparam logic [11:0] OFS_CORESTATUS    = 12'h0A0;
  localparam logic [11:0] OFS_CS_RO         = 12'h0C0;  // read-only mirror of corestatus
  localparam logic [11:0] OFS_BOOTSEL       = 12'h0C4;

  // paddr[11:10] of the direct pad window, paddr[9:2] is the pad index
  localparam logic [1:0] PAD_WIN_TAG = 2'b01;

  localparam logic [31:0] FCBOOT_RST  = 32'h1A00_0080;
  localparam logic [31:0] RDATA_ERR   = 32'hDEAD_BEEF;
  localparam logic [31:0] RDATA_NOPAD = 32'h0095_BEEF;

  typedef enum logic [3:0] {
    REG_NONE,
    REG_INFO,
    REG_FCBOOT,
    REG_FCFETCH,
    REG_WCFG,
    REG_RCFG,
    REG_CLU_CTRL,
    REG_JTAG,
    REG_CLU_IRQ,
    REG_CLU_BOOT0,
    REG_CLU_BOOT1,
    REG_CORESTATUS,
    REG_CS_RO,
    REG_BOOTSEL,
    REG_PAD
  } soc_reg_e;

  // fetch enable override coming from another clock domain
  typedef struct packed {
    logic valid;
    logic en;
  } fetch_req_t;

endpackage

`default_nettype wire

//--- hdl/soc_ctrl_rdata.sv
// registered read word, loaded on the read strobe and held otherwise
// jtag read packs input above output, so JTAG_REG_SIZE should stay within 16
`default_nettype none

module soc_ctrl_rdata
  import soc_ctrl_pkg::*;
#(
  parameter int unsigned N_IO          = 32,
  parameter int unsigned NB_CORES      = 4,
  parameter int unsigned NB_CLUSTERS   = 1,
  parameter int unsigned JTAG_REG_SIZE = 8
) (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic                             rd_stb_i,
  input  soc_reg_e                         reg_sel_i,
  input  logic [7:0]                       pad_idx_i,
  input  logic [31:0]                      fc_bootaddr_i,
  input  logic                             fc_fetchen_i,
  input  logic                             cluster_byp_i,
  input  logic                             cluster_pow_i,
  input  logic                             cluster_fetch_enable_i,
  input  logic                             cluster_rstn_i,
  input  logic                             cluster_irq_i,
  input  logic [63:0]                      cluster_boot_addr_i,
  input  logic [31:0]                      corestatus_i,
  input  logic [JTAG_REG_SIZE-1:0]         jtag_reg_i,
  input  logic                             bootsel_cap_i,
  input  logic [N_IO-1:0][NBIT_PADCFG-1:0] pad_cfg_i,
  input  logic [N_IO-1:0][NBIT_PADMUX-1:0] pad_mux_i,
  input  logic [7:0]                       pad_ptr_i,
  input  logic [JTAG_REG_SIZE-1:0]         jtag_sync_i,
  input  logic                             bootsel_i,
  output logic [31:0]                      prdata_o
);

  logic [31:0] rdata;
  logic [31:0] ptr_word;  // pointer with the fields of the pad it selects

  always_comb begin
    ptr_word = 32'(pad_ptr_i);
    if (32'(pad_ptr_i) < N_IO) begin  // stale out of range pointer reads no fields
      ptr_word[16+:NBIT_PADMUX] = pad_mux_i[pad_ptr_i];
      ptr_word[24+:NBIT_PADCFG] = pad_cfg_i[pad_ptr_i];
    end
  end

  always_comb begin
    rdata = '0;
    case (reg_sel_i)
      REG_INFO:                  rdata = {16'(NB_CORES), 16'(NB_CLUSTERS)};
      REG_FCBOOT:                rdata = fc_bootaddr_i;
      REG_FCFETCH:               rdata[0] = fc_fetchen_i;
      REG_WCFG, REG_RCFG:        rdata = ptr_word;
      REG_CLU_CTRL:
        rdata[3:0] = {cluster_rstn_i, cluster_fetch_enable_i, cluster_pow_i, cluster_byp_i};
      REG_JTAG:                  rdata = 32'({jtag_sync_i, jtag_reg_i});
      REG_CLU_IRQ:               rdata[0] = cluster_irq_i;
      REG_CLU_BOOT0:             rdata = cluster_boot_addr_i[31:0];
      REG_CLU_BOOT1:             rdata = cluster_boot_addr_i[63:32];
      REG_CORESTATUS, REG_CS_RO: rdata = corestatus_i;
      REG_BOOTSEL:               rdata = {bootsel_i, 30'h0, bootsel_cap_i};
      REG_PAD: begin
        rdata[8+:NBIT_PADCFG] = pad_cfg_i[pad_idx_i];
        rdata[0+:NBIT_PADMUX] = pad_mux_i[pad_idx_i];
      end
      // nonzero index on REG_NONE means a pad window miss
      default: rdata = (pad_idx_i != '0) ? RDATA_NOPAD : RDATA_ERR;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      prdata_o <= '0;
    end else if (rd_stb_i) begin
      prdata_o <= rdata;
    end
  end

endmodule

`default_nettype wire

//--- hdl/soc_ctrl_regs.sv
// scalar control registers written by the sequencer strobe
// a bus write to fcfetch wins over the synchronized fetch override
// bootsel is captured once, on the first edge after reset release
`default_nettype none

module soc_ctrl_regs
  import soc_ctrl_pkg::*;
#(
  parameter int unsigned JTAG_REG_SIZE = 8
) (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     wr_stb_i,
  input  soc_reg_e                 reg_sel_i,
  input  logic [31:0]              pwdata_i,
  input  fetch_req_t               fetch_req_i,
  input  logic                     bootsel_i,
  output logic [31:0]              fc_bootaddr_o,
  output logic                     fc_fetchen_o,
  output logic                     cluster_byp_o,
  output logic                     cluster_pow_o,
  output logic                     cluster_fetch_enable_o,
  output logic                     cluster_rstn_o,
  output logic                     cluster_irq_o,
  output logic [63:0]              cluster_boot_addr_o,
  output logic [31:0]              corestatus_o,
  output logic [JTAG_REG_SIZE-1:0] jtag_reg_o,
  output logic                     bootsel_cap_o
);

  logic cap_pending_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      fc_bootaddr_o          <= FCBOOT_RST;
      fc_fetchen_o           <= 1'b0;  // fc stays idle until enabled
      cluster_byp_o          <= 1'b1;
      cluster_pow_o          <= 1'b0;
      cluster_fetch_enable_o <= 1'b0;
      cluster_rstn_o         <= 1'b1;
      cluster_irq_o          <= 1'b0;
      cluster_boot_addr_o    <= '0;
      corestatus_o           <= '0;
      jtag_reg_o             <= '0;
    end else begin
      if (fetch_req_i.valid) fc_fetchen_o <= fetch_req_i.en;
      if (wr_stb_i) begin
        case (reg_sel_i)
          REG_FCBOOT:     fc_bootaddr_o <= pwdata_i;
          REG_FCFETCH:    fc_fetchen_o  <= pwdata_i[0];  // overrides the line above
          REG_CLU_CTRL: begin
            cluster_byp_o          <= pwdata_i[0];
            cluster_pow_o          <= pwdata_i[1];
            cluster_fetch_enable_o <= pwdata_i[2];
            cluster_rstn_o         <= pwdata_i[3];
          end
          REG_CLU_IRQ:    cluster_irq_o              <= pwdata_i[0];
          REG_CLU_BOOT0:  cluster_boot_addr_o[31:0]  <= pwdata_i;
          REG_CLU_BOOT1:  cluster_boot_addr_o[63:32] <= pwdata_i;
          REG_CORESTATUS: corestatus_o               <= pwdata_i;
          REG_JTAG:       jtag_reg_o                 <= pwdata_i[JTAG_REG_SIZE-1:0];
          default: ;
        endcase
      end
    end
  end

  // one-shot capture of the boot select strap
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      cap_pending_q <= 1'b1;
      bootsel_cap_o <= 1'b0;
    end else if (cap_pending_q) begin
      cap_pending_q <= 1'b0;
      bootsel_cap_o <= bootsel_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/soc_ctrl_sync.sv
// two flop synchronizer for slow quasi-static inputs
// a multi-bit payload must not change more than once per few cycles
`default_nettype none

module soc_ctrl_sync #(
  parameter type T = logic
) (
  input  logic HCLK,
  input  logic HRESETn,
  input  T     d_i,
  output T     q_o
);

  T meta_q;  // first stage, may go metastable

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      meta_q <= '0;
      q_o    <= '0;
    end else begin
      meta_q <= d_i;
      q_o    <= meta_q;
    end
  end

endmodule

`default_nettype wire

//--- hdl/soc_ctrl_top.sv
// soc control register block, apb slave with a fixed three cycle access
// N_IO at most 256, soc_jtag_reg_i and the fetch override may be asynchronous
`default_nettype none

module soc_ctrl_top
  import soc_ctrl_pkg::*;
#(
  parameter int unsigned N_IO          = 32,
  parameter int unsigned NB_CORES      = 4,
  parameter int unsigned NB_CLUSTERS   = 1,
  parameter int unsigned JTAG_REG_SIZE = 8
) (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic [APB_ADDR_WIDTH-1:0]        paddr_i,
  input  logic [31:0]                      pwdata_i,
  input  logic                             pwrite_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  output logic [31:0]                      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  input  logic                             bootsel_i,
  input  logic                             fc_fetch_en_valid_i,
  input  logic                             fc_fetch_en_i,
  input  logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_i,
  output logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_o,
  output logic [N_IO-1:0][NBIT_PADCFG-1:0] pad_cfg_o,
  output logic [N_IO-1:0][NBIT_PADMUX-1:0] pad_mux_o,
  output logic [31:0]                      fc_bootaddr_o,
  output logic                             fc_fetchen_o,
  output logic                             cluster_byp_o,
  output logic                             cluster_pow_o,
  output logic                             cluster_fetch_enable_o,
  output logic                             cluster_rstn_o,
  output logic                             cluster_irq_o,
  output logic [63:0]                      cluster_boot_addr_o
);

  logic                     wr_stb;
  logic                     rd_stb;
  soc_reg_e                 reg_sel;
  logic [7:0]               pad_idx;
  logic [7:0]               pad_ptr;
  logic [31:0]              corestatus;
  logic                     bootsel_cap;
  logic [JTAG_REG_SIZE-1:0] jtag_sync;
  fetch_req_t               fetch_req_async;
  fetch_req_t               fetch_req_sync;

  assign fetch_req_async = '{valid: fc_fetch_en_valid_i, en: fc_fetch_en_i};

  soc_ctrl_apb_seq #(.N_IO(N_IO)) apb_seq_inst (
    .HCLK, .HRESETn, .paddr_i, .pwrite_i, .psel_i, .penable_i, .pready_o, .pslverr_o,
    .wr_stb_o(wr_stb), .rd_stb_o(rd_stb), .reg_sel_o(reg_sel), .pad_idx_o(pad_idx)
  );

  soc_ctrl_sync #(.T(logic [JTAG_REG_SIZE-1:0])) jtag_sync_inst (
    .HCLK, .HRESETn, .d_i(soc_jtag_reg_i), .q_o(jtag_sync)
  );

  soc_ctrl_sync #(.T(fetch_req_t)) fetch_sync_inst (
    .HCLK, .HRESETn, .d_i(fetch_req_async), .q_o(fetch_req_sync)
  );

  soc_ctrl_regs #(.JTAG_REG_SIZE(JTAG_REG_SIZE)) regs_inst (
    .HCLK, .HRESETn, .wr_stb_i(wr_stb), .reg_sel_i(reg_sel), .pwdata_i,
    .fetch_req_i(fetch_req_sync), .bootsel_i, .fc_bootaddr_o, .fc_fetchen_o,
    .cluster_byp_o, .cluster_pow_o, .cluster_fetch_enable_o, .cluster_rstn_o,
    .cluster_irq_o, .cluster_boot_addr_o, .corestatus_o(corestatus),
    .jtag_reg_o(soc_jtag_reg_o), .bootsel_cap_o(bootsel_cap)
  );

  soc_ctrl_padcfg #(.N_IO(N_IO)) padcfg_inst (
    .HCLK, .HRESETn, .wr_stb_i(wr_stb), .rd_stb_i(rd_stb), .reg_sel_i(reg_sel),
    .pad_idx_i(pad_idx), .pwdata_i, .pad_cfg_o, .pad_mux_o, .pad_ptr_o(pad_ptr)
  );

  soc_ctrl_rdata #(
    .N_IO(N_IO), .NB_CORES(NB_CORES), .NB_CLUSTERS(NB_CLUSTERS),
    .JTAG_REG_SIZE(JTAG_REG_SIZE)
  ) rdata_inst (
    .HCLK, .HRESETn, .rd_stb_i(rd_stb), .reg_sel_i(reg_sel), .pad_idx_i(pad_idx),
    .fc_bootaddr_i(fc_bootaddr_o), .fc_fetchen_i(fc_fetchen_o),
    .cluster_byp_i(cluster_byp_o), .cluster_pow_i(cluster_pow_o),
    .cluster_fetch_enable_i(cluster_fetch_enable_o), .cluster_rstn_i(cluster_rstn_o),
    .cluster_irq_i(cluster_irq_o), .cluster_boot_addr_i(cluster_boot_addr_o),
    .corestatus_i(corestatus), .jtag_reg_i(soc_jtag_reg_o), .bootsel_cap_i(bootsel_cap),
    .pad_cfg_i(pad_cfg_o), .pad_mux_i(pad_mux_o), .pad_ptr_i(pad_ptr),
    .jtag_sync_i(jtag_sync), .bootsel_i, .prdata_o
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the soc_ctrl testbench with verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module soc_ctrl_tb \
  -f soc_ctrl_top.f -o soc_ctrl_sim

# a failing run exits nonzero, the log search below gives the verdict
./obj_dir/soc_ctrl_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failures found" "$LOG" || ! grep -q "All tests passed!" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
echo "simulation ok"

//--- soc_ctrl_top.f
hdl/soc_ctrl_pkg.sv
hdl/soc_ctrl_sync.sv
hdl/soc_ctrl_apb_seq.sv
hdl/soc_ctrl_regs.sv
hdl/soc_ctrl_padcfg.sv
hdl/soc_ctrl_rdata.sv
hdl/soc_ctrl_top.sv
bench/soc_ctrl_props.sv
bench/soc_ctrl_tb.sv
